//--- bench/rx_vectors.txt
// records of hex tokens: 1 test_id | 2 cnt err fail bytes | 3 cnt err fail seed bad_crc
// 4 len (read oldest frame) | 5 unread | 6 unread (after clear) | 0 end of vectors
// single good frame
1 1
2 8 0 0 01 03 00 00 00 01 84 0A
4 7
5 0
// corrupted crc, data kept
1 2
2 8 1 0 01 03 00 00 00 01 84 0B
4 7
5 0
// lengths 1, 33 and 200 in arrival order
1 3
2 1 1 0 5A
3 21 0 0 10 0
3 C8 0 0 40 0
4 0
4 20
4 C7
5 0
// eight frames of 8 slots fill the buffer, the ninth does not fit
1 4
3 100 0 0 01 0
3 100 0 0 21 0
3 100 0 0 41 0
3 100 0 0 61 0
3 100 0 0 81 0
3 100 0 0 A1 0
3 100 0 0 C1 0
3 100 0 0 E1 0
3 A 0 1 77 0
4 FF
4 FF
4 FF
4 FF
4 FF
4 FF
4 FF
4 FF
5 0
// clear with frames pending, then a fresh frame
1 5
3 10 0 0 33 0
3 30 0 0 44 0
5 1
6 0
3 18 0 0 55 0
4 17
5 0
// frame longer than 256 bytes
1 6
3 12C 1 0 66 0
4 FF
5 0
0

//--- sim.f
hdl/rx_pkg.sv
hdl/rx_frame_if.sv
hdl/rx_sdp_ram.sv
hdl/rx_frame_writer.sv
hdl/rx_frame_buf.sv
hdl/rx_buffer_top.sv
bench/tb_rx_buffer.sv

//--- Makefile
# Verilator build and run for the rx frame buffer testbench

VERILATOR  ?= verilator
TOP        ?= tb_rx_buffer
RTL_TOP    ?= rx_buffer_top
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= No errors
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint lint_rtl sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

lint_rtl:
	$(VERILATOR) $(LINT_FLAGS) hdl/rx_pkg.sv hdl/rx_frame_if.sv hdl/rx_sdp_ram.sv \
		hdl/rx_frame_writer.sv hdl/rx_frame_buf.sv hdl/rx_buffer_top.sv \
		--top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_rx_buffer.sv
// testbench for the rx frame buffer
// replays frame, read and clear records from a vector file and checks
// read words, lengths, error flags, unread and switch_fail

`timescale 1ns/100ps

module tb_rx_buffer;

    localparam int VEC_DEPTH  = 512;
    localparam int RING_DEPTH = 4096;
    localparam int WAIT_LIMIT = 200;

    logic        clk;
    logic        reset_n;
    logic [7:0]  rx_byte;
    logic        rx_byte_valid;
    logic        rx_frame_end;
    logic [5:0]  rd_addr;
    logic        rd_en;
    logic        rd_done;
    logic        rd_done_all;
    logic [31:0] rd_word;
    logic [7:0]  rd_len;
    logic        rd_err;
    logic        unread;
    logic        switch_fail;

    logic [15:0] vec_mem [VEC_DEPTH];
    logic [7:0]  frame_bytes [512];      // bytes of the frame being sent
    logic [7:0]  sent_ring [RING_DEPTH]; // bytes of frames still expected in the buffer
    int          ring_wp;
    int          pend_start[$];
    logic        pend_err[$];
    logic [31:0] lcg_state;
    int          vp;
    int          checks;
    int          failures;
    int          tests;
    int          test_id;
    int          test_fail_base;

    rx_buffer_top UUT (
        .clk           (clk),
        .reset_n       (reset_n),
        .rx_byte       (rx_byte),
        .rx_byte_valid (rx_byte_valid),
        .rx_frame_end  (rx_frame_end),
        .rd_addr       (rd_addr),
        .rd_en         (rd_en),
        .rd_done       (rd_done),
        .rd_done_all   (rd_done_all),
        .rd_word       (rd_word),
        .rd_len        (rd_len),
        .rd_err        (rd_err),
        .unread        (unread),
        .switch_fail   (switch_fail)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // reference crc, one byte shifted through lsb first
    function automatic logic [15:0] crc16_byte(input logic [15:0] c_in, input logic [7:0] d);
        logic [15:0] c;
        c = c_in ^ {8'h00, d};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ rx_pkg::CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    function automatic logic [15:0] next_vec();
        logic [15:0] v;
        v = (vp < VEC_DEPTH) ? vec_mem[vp] : 16'h0000;  // past the end reads as end record
        vp = vp + 1;
        return v;
    endfunction

    task automatic check_word(input int idx, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            failures++;
            $display("Error: rd_word[%0d] = %h, expected %h", idx, got, exp);
        end
    endtask

    task automatic check_len_err(input logic [7:0] got_len, input logic got_err,
                                 input logic [7:0] exp_len, input logic exp_err);
        checks++;
        if (got_len !== exp_len || got_err !== exp_err) begin
            failures++;
            $display("Error: rd_len = %h rd_err = %h, expected rd_len = %h rd_err = %h",
                     got_len, got_err, exp_len, exp_err);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            failures++;
            $display("Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic wait_unread(output logic seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < WAIT_LIMIT) begin
            @(negedge clk);
            seen = (unread === 1'b1);
            n++;
        end
        if (!seen) begin
            failures++;
            $display("unread did not rise within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic send_frame(input int cnt, input logic exp_fail);
        int   gap;
        logic seen_fail;
        for (int i = 0; i < cnt; i++) begin
            @(negedge clk);
            rx_byte       = frame_bytes[i];
            rx_byte_valid = 1'b1;
            @(negedge clk);
            rx_byte_valid = 1'b0;
            lcg_state     = lcg_next(lcg_state);
            gap           = int'(lcg_state[17:16]) % 3;  // 0 to 2 idle cycles
            repeat (gap) @(negedge clk);
        end
        @(negedge clk);
        rx_frame_end = 1'b1;
        @(negedge clk);
        rx_frame_end = 1'b0;
        seen_fail = 1'b0;
        for (int i = 0; i < 6; i++) begin  // the pulse comes two cycles after switch
            @(negedge clk);
            if (switch_fail === 1'b1) begin
                seen_fail = 1'b1;
            end
        end
        check_flag("switch_fail", seen_fail, exp_fail);
    endtask

    task automatic run_frame(input logic pattern);
        int          cnt;
        int          crc_end;
        logic        exp_err;
        logic        exp_fail;
        logic [7:0]  seed;
        logic        bad_crc;
        logic [15:0] crc;
        logic [15:0] v;
        cnt = int'(next_vec());
        v = next_vec();
        exp_err = v[0];
        v = next_vec();
        exp_fail = v[0];
        if (pattern) begin
            v = next_vec();
            seed = v[7:0];
            v = next_vec();
            bad_crc = v[0];
            crc_end = (cnt > 256) ? 256 : cnt;  // an overlong frame carries its crc in byte 256
            for (int i = 0; i < cnt; i++) begin
                frame_bytes[i] = seed + 8'(i);
            end
            crc = rx_pkg::CRC_INIT;
            for (int i = 0; i < crc_end - 2; i++) begin
                crc = crc16_byte(crc, frame_bytes[i]);
            end
            frame_bytes[crc_end-2] = crc[7:0];  // crc goes out low byte first
            frame_bytes[crc_end-1] = crc[15:8] ^ {7'h00, bad_crc};
        end else begin
            for (int i = 0; i < cnt; i++) begin
                v = next_vec();
                frame_bytes[i] = v[7:0];
            end
        end
        if (!exp_fail) begin
            pend_start.push_back(ring_wp);
            pend_err.push_back(exp_err);
            for (int i = 0; i < cnt; i++) begin
                sent_ring[(ring_wp + i) % RING_DEPTH] = frame_bytes[i];
            end
            ring_wp = (ring_wp + cnt) % RING_DEPTH;
        end
        send_frame(cnt, exp_fail);
    endtask

    task automatic run_read();
        logic [15:0] v;
        logic [7:0]  exp_len;
        logic        exp_err;
        logic        seen;
        logic [31:0] exp_word;
        int          start;
        int          nbytes;
        v = next_vec();
        exp_len = v[7:0];
        if (pend_start.size() == 0) begin
            failures++;
            $display("read record found no stored frame to compare with");
            return;
        end
        start = pend_start.pop_front();
        exp_err = pend_err.pop_front();
        nbytes = int'(exp_len) + 1;
        wait_unread(seen);
        if (!seen) begin
            return;
        end
        repeat (2) @(negedge clk);  // index entry settles after the pointer moves
        check_len_err(rd_len, rd_err, exp_len, exp_err);
        for (int w = 0; w < (nbytes + 3) / 4; w++) begin
            @(negedge clk);
            rd_addr = 6'(w);
            rd_en   = 1'b1;
            @(negedge clk);
            rd_en    = 1'b0;
            exp_word = '0;
            for (int b = 0; b < 4; b++) begin
                if (w * 4 + b < nbytes) begin
                    exp_word[b*8 +: 8] = sent_ring[(start + w * 4 + b) % RING_DEPTH];
                end
            end
            check_word(w, rd_word, exp_word);
        end
        @(negedge clk);
        rd_done = 1'b1;
        @(negedge clk);
        rd_done = 1'b0;
    endtask

    task automatic run_unread_check();
        logic [15:0] v;
        v = next_vec();
        @(negedge clk);
        check_flag("unread", unread, v[0]);
    endtask

    task automatic run_clear();
        logic [15:0] v;
        v = next_vec();
        @(negedge clk);
        rd_done_all = 1'b1;
        @(negedge clk);
        rd_done_all = 1'b0;
        pend_start.delete();
        pend_err.delete();
        check_flag("unread", unread, v[0]);
    endtask

    task automatic finish_test();
        if (test_id >= 0) begin
            tests++;
            $display("test %0d finished, %0d failed checks", test_id, failures - test_fail_base);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        logic [15:0] op;
        logic        done;
        reset_n        = 1'b0;
        rx_byte        = 8'h00;
        rx_byte_valid  = 1'b0;
        rx_frame_end   = 1'b0;
        rd_addr        = 6'd0;
        rd_en          = 1'b0;
        rd_done        = 1'b0;
        rd_done_all    = 1'b0;
        lcg_state      = 32'd34;
        ring_wp        = 0;
        vp             = 0;
        checks         = 0;
        failures       = 0;
        tests          = 0;
        test_id        = -1;
        test_fail_base = 0;
        for (int i = 0; i < VEC_DEPTH; i++) begin
            vec_mem[i] = '0;
        end
        $readmemh("bench/rx_vectors.txt", vec_mem);
        repeat (8) @(negedge clk);
        reset_n = 1'b1;
        done = 1'b0;
        while (!done) begin
            op = next_vec();
            case (op)
                16'h0: done = 1'b1;
                16'h1: begin
                    finish_test();
                    test_id = int'(next_vec());
                    test_fail_base = failures;
                end
                16'h2: run_frame(1'b0);  // bytes listed in the record
                16'h3: run_frame(1'b1);  // counting pattern plus crc
                16'h4: run_read();
                16'h5: run_unread_check();
                16'h6: run_clear();
                default: begin
                    failures++;
                    $display("unknown record type %h in the vector file", op);
                    done = 1'b1;
                end
            endcase
        end
        finish_test();
        $display("tests %0d, checks %0d, failed checks %0d", tests, checks, failures);
        if (failures == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- hdl/rx_buffer_top.sv
// rx buffer top level
// frame writer and frame buffer joined by the write interface,
// receive and read sides on plain ports

`timescale 1ns/100ps

module rx_buffer_top (
    input  logic        clk,
    input  logic        reset_n,

    // receive side
    input  logic [7:0]  rx_byte,
    input  logic        rx_byte_valid,
    input  logic        rx_frame_end,

    // read side
    input  logic [5:0]  rd_addr,      // word index within the frame
    input  logic        rd_en,
    input  logic        rd_done,
    input  logic        rd_done_all,
    output logic [31:0] rd_word,
    output logic [7:0]  rd_len,
    output logic        rd_err,
    output logic        unread,
    output logic        switch_fail
);

    rx_frame_if frame_if ();

    assign switch_fail = frame_if.switch_fail;

    rx_frame_writer u_writer (
        .clk           (clk),
        .reset_n       (reset_n),
        .rx_byte       (rx_byte),
        .rx_byte_valid (rx_byte_valid),
        .rx_frame_end  (rx_frame_end),
        .wr            (frame_if.writer)
    );

    rx_frame_buf u_buf (
        .clk         (clk),
        .reset_n     (reset_n),
        .wr          (frame_if.buffer),
        .rd_word     (rd_word),
        .rd_addr     (rd_addr),
        .rd_en       (rd_en),
        .rd_done     (rd_done),
        .rd_done_all (rd_done_all),
        .unread      (unread),
        .rd_err      (rd_err),
        .rd_len      (rd_len)
    );

endmodule

//--- hdl/rx_frame_buf.sv
// rx frame buffer
// 64 slots of 32 bytes, a frame occupies one or more consecutive slots;
// an index entry per frame holds its length and fragment count,
// frames are read back as 32-bit words in arrival order

`timescale 1ns/100ps

module rx_frame_buf (
    input  logic          clk,
    input  logic          reset_n,
    rx_frame_if.buffer    wr,
    output logic [31:0]   rd_word,
    input  logic [5:0]    rd_addr,
    input  logic          rd_en,
    input  logic          rd_done,
    input  logic          rd_done_all,
    output logic          unread,
    output logic          rd_err,
    output logic [7:0]    rd_len
);

    logic [rx_pkg::IDX_WIDTH-1:0]   wr_sel;  // first slot of the frame being written
    logic [rx_pkg::IDX_WIDTH-1:0]   rd_sel;  // first slot of the oldest frame
    logic [rx_pkg::SLOT_COUNT-1:0]  dirty;
    logic [rx_pkg::SLOT_COUNT-1:0]  error;

    logic [rx_pkg::IDX_WIDTH-1:0]   wr_slot;
    logic [rx_pkg::WADDR_WIDTH-1:0] wr_waddr;
    logic [31:0]                    wr_word;
    logic                           wr_en_d;
    logic                           wr_cancel;
    logic                           switch_d;
    logic                           wr_err_q;
    logic [7:0]                     wr_len_q;
    logic [rx_pkg::FRAG_WIDTH-1:0]  wr_frag_amount;

    logic [rx_pkg::WADDR_WIDTH-1:0] rd_base;
    logic [rx_pkg::WADDR_WIDTH-1:0] rd_ra;
    logic [rx_pkg::WADDR_WIDTH-1:0] rd_ra_q;

    rx_pkg::idx_entry_t             idx_wd;
    rx_pkg::idx_entry_t             idx_rd;
    logic                           idx_we;

    assign unread = dirty[rd_sel];
    assign rd_err = error[rd_sel];
    assign rd_len = idx_rd.len;

    // slot that the incoming byte lands in
    assign wr_slot = wr_sel + rx_pkg::IDX_WIDTH'(wr.wr_addr[7:rx_pkg::BLK_WIDTH]);

    // word address of the read, held between reads so rd_word stays put
    assign rd_base = {rd_sel, {(rx_pkg::BLK_WIDTH-2){1'b0}}}
                   + rx_pkg::WADDR_WIDTH'(rd_addr);
    assign rd_ra   = rd_en ? rd_base : rd_ra_q;

    always_comb begin
        idx_wd.frag_amount = wr_frag_amount;
        idx_wd.len         = wr_len_q;
    end
    assign idx_we = switch_d && !wr_cancel;

    // little-endian word assembly, lanes above the new byte read as zero
    always_ff @(posedge clk) begin
        if (wr.wr_en) begin
            case (wr.wr_addr[1:0])
                2'b00:   wr_word <= {24'h0, wr.wr_byte};
                2'b01:   wr_word <= {16'h0, wr.wr_byte, wr_word[7:0]};
                2'b10:   wr_word <= {8'h0, wr.wr_byte, wr_word[15:0]};
                default: wr_word <= {wr.wr_byte, wr_word[23:0]};
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_sel         <= '0;
            rd_sel         <= '0;
            dirty          <= '0;
            error          <= '0;
            wr_waddr       <= '0;
            wr_en_d        <= 1'b0;
            wr_cancel      <= 1'b0;
            switch_d       <= 1'b0;
            wr_err_q       <= 1'b0;
            wr_len_q       <= '0;
            wr_frag_amount <= '0;
            rd_ra_q        <= '0;
            wr.switch_fail <= 1'b0;
        end else begin
            wr.switch_fail <= 1'b0;
            wr_en_d        <= 1'b0;
            switch_d       <= wr.switch;
            rd_ra_q        <= rd_ra;
            wr_waddr       <= {wr_slot, wr.wr_addr[rx_pkg::BLK_WIDTH-1:2]};

            if (wr.switch) begin
                wr_err_q <= wr.wr_err;
                wr_len_q <= wr.wr_len;
            end

            if (wr.wr_en && !wr_cancel) begin
                if (dirty[wr_slot]) begin
                    wr_cancel <= 1'b1;  // would overwrite an unread frame
                end else begin
                    wr_en_d        <= 1'b1;
                    wr_frag_amount <= wr.wr_addr[7:rx_pkg::BLK_WIDTH];
                end
            end

            if (switch_d) begin
                if (wr_cancel) begin
                    wr.switch_fail <= 1'b1;
                end else begin
                    dirty[wr_sel] <= 1'b1;
                    error[wr_sel] <= wr_err_q;
                    wr_sel        <= wr_sel + rx_pkg::IDX_WIDTH'(wr_frag_amount) + 1'b1;
                end
                wr_cancel <= 1'b0;
            end

            // release the oldest frame and skip its fragments
            if (rd_done && dirty[rd_sel]) begin
                dirty[rd_sel] <= 1'b0;
                rd_sel        <= rd_sel + rx_pkg::IDX_WIDTH'(idx_rd.frag_amount) + 1'b1;
            end

            if (rd_done_all) begin
                wr_sel         <= '0;
                rd_sel         <= '0;
                dirty          <= '0;
                error          <= '0;
                wr_cancel      <= 1'b0;
                switch_d       <= 1'b0;
                wr.switch_fail <= 1'b0;
            end
        end
    end

    rx_sdp_ram #(
        .ADDR_WIDTH (rx_pkg::WADDR_WIDTH),
        .word_t     (logic [31:0])
    ) u_data_ram (
        .clk (clk),
        .ra  (rd_ra),
        .rd  (rd_word),
        .wa  (wr_waddr),
        .wd  (wr_word),
        .we  (wr_en_d)
    );

    rx_sdp_ram #(
        .ADDR_WIDTH (rx_pkg::IDX_WIDTH),
        .word_t     (rx_pkg::idx_entry_t)
    ) u_idx_ram (
        .clk (clk),
        .ra  (rd_sel),
        .rd  (idx_rd),
        .wa  (wr_sel),
        .wd  (idx_wd),
        .we  (idx_we)
    );

    // a frame whose first slot is still unread is refused with switch_fail
    a_full_fails: assert property (
        @(posedge clk) disable iff (!reset_n)
        switch_d && dirty[wr_sel] && !rd_done_all |=> wr.switch_fail
    );

endmodule

//--- hdl/rx_frame_writer.sv
// rx frame writer
// turns the received byte stream into buffer writes, counts the frame
// length, checks the CRC-16 and issues the frame switch at frame end

`timescale 1ns/100ps

module rx_frame_writer (
    input  logic          clk,
    input  logic          reset_n,
    input  logic [7:0]    rx_byte,
    input  logic          rx_byte_valid,
    input  logic          rx_frame_end,
    rx_frame_if.writer    wr
);

    logic [8:0]  byte_cnt;   // 0 .. 256
    logic [15:0] crc;
    logic        overflow;   // bytes beyond 256 were dropped
    logic        byte_take;

    // one byte through the reflected polynomial, lsb first
    function automatic logic [15:0] crc_step(input logic [15:0] crc_in,
                                             input logic [7:0]  data);
        logic [15:0] c;
        c = crc_in ^ {8'h00, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ rx_pkg::CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    assign byte_take = rx_byte_valid && !byte_cnt[8];  // room left in the frame

    // byte counter, crc and overflow tracking
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            byte_cnt <= '0;
            crc      <= rx_pkg::CRC_INIT;
            overflow <= 1'b0;
        end else if (rx_frame_end) begin
            byte_cnt <= '0;
            crc      <= rx_pkg::CRC_INIT;
            overflow <= 1'b0;
        end else if (rx_byte_valid) begin
            if (byte_take) begin
                byte_cnt <= byte_cnt + 9'd1;
                crc      <= crc_step(crc, rx_byte);
            end else begin
                overflow <= 1'b1;
            end
        end
    end

    // payload copy, qualified by wr_en
    always_ff @(posedge clk) begin
        if (byte_take) begin
            wr.wr_byte <= rx_byte;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr.wr_en   <= 1'b0;
            wr.wr_addr <= '0;
            wr.switch  <= 1'b0;
            wr.wr_err  <= 1'b0;
            wr.wr_len  <= '0;
        end else begin
            wr.wr_en  <= byte_take;
            wr.switch <= rx_frame_end && (byte_cnt != 9'd0);  // empty frames vanish
            if (byte_take) begin
                wr.wr_addr <= byte_cnt[7:0];
            end
            if (rx_frame_end) begin
                wr.wr_len <= 8'(byte_cnt - 9'd1);        // 256 bytes gives 255
                wr.wr_err <= (crc != 16'h0000) || overflow;  // good frame leaves zero residue
            end
        end
    end

    // the line receiver never ends a frame on a data byte
    a_no_byte_at_end: assert property (
        @(posedge clk) disable iff (!reset_n)
        !(rx_byte_valid && rx_frame_end)
    );

endmodule

//--- hdl/rx_sdp_ram.sv
// simple dual-port RAM
// one write port and one registered read port, word type set by parameter

`timescale 1ns/100ps

module rx_sdp_ram #(
    parameter int  ADDR_WIDTH = 9,
    parameter type word_t     = logic [31:0]
) (
    input  logic                  clk,
    input  logic [ADDR_WIDTH-1:0] ra,
    output word_t                 rd,
    input  logic [ADDR_WIDTH-1:0] wa,
    input  word_t                 wd,
    input  logic                  we
);

    word_t mem [2**ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wa] <= wd;
        end
        rd <= mem[ra];  // old data on a same-address write
    end

    // an unknown address on a write would corrupt an arbitrary word
    a_addr_known: assert property (@(posedge clk) we |-> !$isunknown({ra, wa}));

endmodule

//--- hdl/rx_frame_if.sv
// rx frame write interface
// byte writes, frame length and error, and the frame switch
// from the frame writer into the frame buffer

`timescale 1ns/100ps

interface rx_frame_if;

    logic [7:0] wr_byte;      // received byte
    logic [7:0] wr_addr;      // byte offset within the frame
    logic       wr_en;        // one strobe per byte
    logic       wr_err;       // valid with switch
    logic [7:0] wr_len;       // valid with switch
    logic       switch;       // pulse after the last byte
    logic       switch_fail;  // frame could not be stored

    modport writer (
        output wr_byte, wr_addr, wr_en, wr_err, wr_len, switch,
        input  switch_fail
    );

    modport buffer (
        input  wr_byte, wr_addr, wr_en, wr_err, wr_len, switch,
        output switch_fail
    );

endinterface

//--- hdl/rx_pkg.sv
// rx buffer package
// geometry of the receive frame buffer, the index entry layout
// and the CRC-16 constants shared by the frame writer and the testbench

package rx_pkg;

    // buffer geometry
    localparam int IDX_WIDTH   = 6;                      // 64 slots
    localparam int BUF_WIDTH   = 11;                     // 2048 bytes
    localparam int BLK_WIDTH   = BUF_WIDTH - IDX_WIDTH;  // 32 bytes per slot
    localparam int FRAG_WIDTH  = 8 - BLK_WIDTH;          // up to 8 slots per frame
    localparam int SLOT_COUNT  = 2 ** IDX_WIDTH;
    localparam int WADDR_WIDTH = BUF_WIDTH - 2;          // 32-bit word address

    // one entry per stored frame, kept at the frame's first slot
    typedef struct packed {
        logic [FRAG_WIDTH-1:0] frag_amount;  // extra slots after the first
        logic [7:0]            len;          // frame length incl. crc, minus one
    } idx_entry_t;

    // CRC-16, modbus flavour, reflected
    localparam logic [15:0] CRC_INIT = 16'hFFFF;
    localparam logic [15:0] CRC_POLY = 16'hA001;

endpackage
